// File: Bender.yml
package:
  name: ccu

export_include_dirs:
  - hdl

sources:
  - hdl/ccu_pkg.sv
  - hdl/ccu_vq_entry.sv
  - hdl/ccu_vq.sv
  - hdl/ccu_fill.sv
  - hdl/ccu_arb.sv
  - hdl/ccu_top.sv
  - target: test
    files:
      - testbench/ccu_props.sv
      - testbench/ccu_tb.sv

// File: ccu.f
+incdir+hdl
hdl/ccu_pkg.sv
hdl/ccu_vq_entry.sv
hdl/ccu_vq.sv
hdl/ccu_fill.sv
hdl/ccu_arb.sv
hdl/ccu_top.sv
testbench/ccu_props.sv
testbench/ccu_tb.sv

// File: hdl/ccu_arb.sv
`timescale 1ns/1ns
`include "ccu_defines.svh"

module ccu_arb (
    input  logic                                            clk,
    input  logic                                            i_reset,
    input  logic                                            i_vq_req,
    input  ccu_pkg::mem_op_t                                i_vq_op,
    input  logic [`CCU_ADDR_WIDTH-1:`CCU_OFFSET_WIDTH]      i_vq_addr,
    input  logic [`CCU_LINE_WIDTH-1:0]                      i_vq_wdata,
    output logic                                            o_vq_done,
    input  logic                                            i_fill_req,
    input  ccu_pkg::mem_op_t                                i_fill_op,
    input  logic [`CCU_ADDR_WIDTH-1:`CCU_OFFSET_WIDTH]      i_fill_addr,
    output logic                                            o_fill_done,
    output logic [`CCU_LINE_WIDTH-1:0]                      o_fill_rdata,
    output logic                                            o_psel,
    output logic                                            o_penable,
    output logic                                            o_pwrite,
    output logic [`CCU_ADDR_WIDTH-1:0]                      o_paddr,
    output logic [`CCU_APB_DATA_WIDTH-1:0]                  o_pwdata,
    input  logic [`CCU_APB_DATA_WIDTH-1:0]                  i_prdata,
    input  logic                                            i_pready
);

    ccu_pkg::arb_state_t state_r;
    ccu_pkg::arb_state_t state_next;
    logic beat_r;
    logic last_r;
    logic owner_r;
    logic grant_fill;
    logic line_done;

    ccu_pkg::mem_op_t op_r;
    logic [`CCU_ADDR_WIDTH-1:`CCU_OFFSET_WIDTH] addr_r;
    logic [`CCU_LINE_WIDTH-1:0] wdata_r;
    logic [`CCU_APB_DATA_WIDTH-1:0] rdata_lo_r;

    // Fill wins if alone, or on a tie when the queue was served last
    assign grant_fill = i_fill_req && (!i_vq_req || !last_r);
    assign line_done  = (state_r == ccu_pkg::ACCESS) && i_pready && beat_r;

    always_comb begin
        state_next = state_r;
        case (state_r)
            ccu_pkg::IDLE:   state_next = (i_vq_req || i_fill_req) ? ccu_pkg::SETUP : state_r;
            ccu_pkg::SETUP:  state_next = ccu_pkg::ACCESS;
            ccu_pkg::ACCESS: begin
                if (i_pready) begin
                    state_next = beat_r ? ccu_pkg::IDLE : ccu_pkg::SETUP;
                end
            end
            default:         state_next = ccu_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state_r <= ccu_pkg::IDLE;
            beat_r  <= 1'b0;
            last_r  <= 1'b1;
        end else begin
            state_r <= state_next;
            if (state_r == ccu_pkg::IDLE) begin
                beat_r <= 1'b0;
            end else if ((state_r == ccu_pkg::ACCESS) && i_pready) begin
                beat_r <= !beat_r;
            end
            if (line_done) begin
                last_r <= owner_r;
            end
        end
    end

    // Latch the winning request for the whole two-beat transfer
    always_ff @(posedge clk) begin
        if ((state_r == ccu_pkg::IDLE) && (i_vq_req || i_fill_req)) begin
            owner_r <= grant_fill;
            op_r    <= grant_fill ? i_fill_op : i_vq_op;
            addr_r  <= grant_fill ? i_fill_addr : i_vq_addr;
            wdata_r <= i_vq_wdata;
        end
        if ((state_r == ccu_pkg::ACCESS) && i_pready && !beat_r) begin
            rdata_lo_r <= i_prdata;
        end
    end

    // Beat 1 sits one word above the line base
    assign o_psel    = (state_r != ccu_pkg::IDLE);
    assign o_penable = (state_r == ccu_pkg::ACCESS);
    assign o_pwrite  = (op_r == ccu_pkg::MEM_OP_WRITE);
    assign o_paddr   = {addr_r, beat_r, {(`CCU_OFFSET_WIDTH-1){1'b0}}};
    assign o_pwdata  = beat_r ? wdata_r[`CCU_LINE_WIDTH-1:`CCU_APB_DATA_WIDTH]
                              : wdata_r[`CCU_APB_DATA_WIDTH-1:0];

    assign o_vq_done    = line_done && !owner_r;
    assign o_fill_done  = line_done && owner_r;
    assign o_fill_rdata = {i_prdata, rdata_lo_r};

endmodule

// File: hdl/ccu_defines.svh
`ifndef CCU_DEFINES_SVH
`define CCU_DEFINES_SVH

// Byte address width on the memory side
`define CCU_ADDR_WIDTH 32

// One cache line, moved as two APB beats
`define CCU_LINE_WIDTH 64

// Byte offset inside a line, the rest of the address is the line address
`define CCU_OFFSET_WIDTH 3

// Victim queue entries, must stay a power of two
`define CCU_VQ_DEPTH 4

// APB data bus width
`define CCU_APB_DATA_WIDTH 32

`endif

// File: hdl/ccu_fill.sv
`timescale 1ns/1ns
`include "ccu_defines.svh"

module ccu_fill (
    input  logic                                            clk,
    input  logic                                            i_reset,
    input  logic                                            i_miss_en,
    input  logic [`CCU_ADDR_WIDTH-1:`CCU_OFFSET_WIDTH]      i_miss_addr,
    input  logic                                            i_vq_hit,
    input  logic [`CCU_LINE_WIDTH-1:0]                      i_vq_data,
    input  logic                                            i_done,
    input  logic [`CCU_LINE_WIDTH-1:0]                      i_rdata,
    output logic [`CCU_ADDR_WIDTH-1:`CCU_OFFSET_WIDTH]      o_lookup_addr,
    output logic                                            o_miss_busy,
    output logic                                            o_req,
    output ccu_pkg::mem_op_t                                o_req_op,
    output logic [`CCU_ADDR_WIDTH-1:`CCU_OFFSET_WIDTH]      o_req_addr,
    output logic                                            o_fill_valid,
    output logic [`CCU_ADDR_WIDTH-1:`CCU_OFFSET_WIDTH]      o_fill_addr,
    output logic [`CCU_LINE_WIDTH-1:0]                      o_fill_data
);

    logic busy_r;
    logic fill_valid_r;
    logic miss_accept;
    logic [`CCU_ADDR_WIDTH-1:`CCU_OFFSET_WIDTH] addr_r;
    logic [`CCU_LINE_WIDTH-1:0] data_r;

    // Queue lookup runs on the incoming miss in the same cycle
    assign o_lookup_addr = i_miss_addr;
    assign miss_accept   = i_miss_en && !busy_r;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            busy_r       <= 1'b0;
            fill_valid_r <= 1'b0;
        end else begin
            fill_valid_r <= (miss_accept && i_vq_hit) || (busy_r && i_done);
            if (miss_accept && !i_vq_hit) begin
                busy_r <= 1'b1;
            end else if (i_done) begin
                busy_r <= 1'b0;
            end
        end
    end

    // Line address is held for the read and reported with the fill
    always_ff @(posedge clk) begin
        if (miss_accept) begin
            addr_r <= i_miss_addr;
        end
        if (miss_accept && i_vq_hit) begin
            data_r <= i_vq_data;
        end else if (busy_r && i_done) begin
            data_r <= i_rdata;
        end
    end

    assign o_miss_busy  = busy_r;
    assign o_req        = busy_r;
    assign o_req_op     = ccu_pkg::MEM_OP_READ;
    assign o_req_addr   = addr_r;
    assign o_fill_valid = fill_valid_r;
    assign o_fill_addr  = addr_r;
    assign o_fill_data  = data_r;

endmodule

// File: hdl/ccu_pkg.sv
`include "ccu_defines.svh"

package ccu_pkg;

    // Victim queue entry occupancy
    typedef enum logic {
        INVALID = 1'b0,
        VALID   = 1'b1
    } vq_entry_state_t;

    // APB master phases
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        SETUP  = 2'b01,
        ACCESS = 2'b10
    } arb_state_t;

    // Request opcode, becomes PWRITE on the bus
    typedef enum logic {
        MEM_OP_READ  = 1'b0,
        MEM_OP_WRITE = 1'b1
    } mem_op_t;

endpackage

// File: hdl/ccu_top.sv
`timescale 1ns/1ns
`include "ccu_defines.svh"

module ccu_top (
    input  logic                                            clk,
    input  logic                                            i_reset,
    input  logic                                            i_victim_en,
    input  logic [`CCU_ADDR_WIDTH-1:`CCU_OFFSET_WIDTH]      i_victim_addr,
    input  logic [`CCU_LINE_WIDTH-1:0]                      i_victim_data,
    output logic                                            o_vq_full,
    input  logic                                            i_miss_en,
    input  logic [`CCU_ADDR_WIDTH-1:`CCU_OFFSET_WIDTH]      i_miss_addr,
    output logic                                            o_miss_busy,
    output logic                                            o_fill_valid,
    output logic [`CCU_ADDR_WIDTH-1:`CCU_OFFSET_WIDTH]      o_fill_addr,
    output logic [`CCU_LINE_WIDTH-1:0]                      o_fill_data,
    output logic                                            o_psel,
    output logic                                            o_penable,
    output logic                                            o_pwrite,
    output logic [`CCU_ADDR_WIDTH-1:0]                      o_paddr,
    output logic [`CCU_APB_DATA_WIDTH-1:0]                  o_pwdata,
    input  logic [`CCU_APB_DATA_WIDTH-1:0]                  i_prdata,
    input  logic                                            i_pready
);

    logic lookup_hit;
    logic [`CCU_LINE_WIDTH-1:0] lookup_data;
    logic [`CCU_ADDR_WIDTH-1:`CCU_OFFSET_WIDTH] lookup_addr;

    // Victim queue request to the arbiter
    logic vq_req;
    logic vq_done;
    ccu_pkg::mem_op_t vq_req_op;
    logic [`CCU_ADDR_WIDTH-1:`CCU_OFFSET_WIDTH] vq_req_addr;
    logic [`CCU_LINE_WIDTH-1:0] vq_req_wdata;

    // Fill request to the arbiter
    logic fill_req;
    logic fill_done;
    ccu_pkg::mem_op_t fill_req_op;
    logic [`CCU_ADDR_WIDTH-1:`CCU_OFFSET_WIDTH] fill_req_addr;
    logic [`CCU_LINE_WIDTH-1:0] fill_rdata;

    ccu_vq vq_i (
        .clk           (clk),
        .i_reset       (i_reset),
        .i_alloc_en    (i_victim_en),
        .i_alloc_addr  (i_victim_addr),
        .i_alloc_data  (i_victim_data),
        .i_lookup_addr (lookup_addr),
        .i_done        (vq_done),
        .o_full        (o_vq_full),
        .o_lookup_hit  (lookup_hit),
        .o_lookup_data (lookup_data),
        .o_req         (vq_req),
        .o_req_op      (vq_req_op),
        .o_req_addr    (vq_req_addr),
        .o_req_wdata   (vq_req_wdata)
    );

    ccu_fill fill_i (
        .clk           (clk),
        .i_reset       (i_reset),
        .i_miss_en     (i_miss_en),
        .i_miss_addr   (i_miss_addr),
        .i_vq_hit      (lookup_hit),
        .i_vq_data     (lookup_data),
        .i_done        (fill_done),
        .i_rdata       (fill_rdata),
        .o_lookup_addr (lookup_addr),
        .o_miss_busy   (o_miss_busy),
        .o_req         (fill_req),
        .o_req_op      (fill_req_op),
        .o_req_addr    (fill_req_addr),
        .o_fill_valid  (o_fill_valid),
        .o_fill_addr   (o_fill_addr),
        .o_fill_data   (o_fill_data)
    );

    ccu_arb arb_i (
        .clk          (clk),
        .i_reset      (i_reset),
        .i_vq_req     (vq_req),
        .i_vq_op      (vq_req_op),
        .i_vq_addr    (vq_req_addr),
        .i_vq_wdata   (vq_req_wdata),
        .o_vq_done    (vq_done),
        .i_fill_req   (fill_req),
        .i_fill_op    (fill_req_op),
        .i_fill_addr  (fill_req_addr),
        .o_fill_done  (fill_done),
        .o_fill_rdata (fill_rdata),
        .o_psel       (o_psel),
        .o_penable    (o_penable),
        .o_pwrite     (o_pwrite),
        .o_paddr      (o_paddr),
        .o_pwdata     (o_pwdata),
        .i_prdata     (i_prdata),
        .i_pready     (i_pready)
    );

endmodule

// File: hdl/ccu_vq.sv
`timescale 1ns/1ns
`include "ccu_defines.svh"

module ccu_vq (
    input  logic                                            clk,
    input  logic                                            i_reset,
    input  logic                                            i_alloc_en,
    input  logic [`CCU_ADDR_WIDTH-1:`CCU_OFFSET_WIDTH]      i_alloc_addr,
    input  logic [`CCU_LINE_WIDTH-1:0]                      i_alloc_data,
    input  logic [`CCU_ADDR_WIDTH-1:`CCU_OFFSET_WIDTH]      i_lookup_addr,
    input  logic                                            i_done,
    output logic                                            o_full,
    output logic                                            o_lookup_hit,
    output logic [`CCU_LINE_WIDTH-1:0]                      o_lookup_data,
    output logic                                            o_req,
    output ccu_pkg::mem_op_t                                o_req_op,
    output logic [`CCU_ADDR_WIDTH-1:`CCU_OFFSET_WIDTH]      o_req_addr,
    output logic [`CCU_LINE_WIDTH-1:0]                      o_req_wdata
);

    localparam int IDX_W = $clog2(`CCU_VQ_DEPTH);

    logic [IDX_W-1:0] head_r;
    logic [IDX_W-1:0] tail_r;
    logic alloc_ok;

    logic [`CCU_VQ_DEPTH-1:0] entry_valid;
    logic [`CCU_VQ_DEPTH-1:0] entry_hit;
    logic [`CCU_ADDR_WIDTH-1:`CCU_OFFSET_WIDTH] entry_addr [`CCU_VQ_DEPTH];
    logic [`CCU_LINE_WIDTH-1:0] entry_data [`CCU_VQ_DEPTH];

    // Entries free up in allocation order, so a valid tail means no room
    assign o_full   = entry_valid[tail_r];
    assign alloc_ok = i_alloc_en && !o_full;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            head_r <= '0;
            tail_r <= '0;
        end else begin
            if (alloc_ok) begin
                tail_r <= tail_r + 1'b1;
            end
            if (i_done) begin
                head_r <= head_r + 1'b1;
            end
        end
    end

    for (genvar i = 0; i < `CCU_VQ_DEPTH; i++) begin : g_entry
        ccu_vq_entry entry_i (
            .clk           (clk),
            .i_reset       (i_reset),
            .i_alloc_en    (alloc_ok && (tail_r == IDX_W'(i))),
            .i_alloc_addr  (i_alloc_addr),
            .i_alloc_data  (i_alloc_data),
            .i_wb_done     (i_done && (head_r == IDX_W'(i))),
            .i_lookup_addr (i_lookup_addr),
            .o_valid       (entry_valid[i]),
            .o_addr        (entry_addr[i]),
            .o_data        (entry_data[i]),
            .o_lookup_hit  (entry_hit[i])
        );
    end

    // Scan oldest to newest so the latest victim of a line wins
    always_comb begin : lookup_reduce
        logic [IDX_W-1:0] idx;
        o_lookup_hit  = 1'b0;
        o_lookup_data = '0;
        for (int i = 0; i < `CCU_VQ_DEPTH; i++) begin
            idx = head_r + IDX_W'(i);
            if (entry_hit[idx]) begin
                o_lookup_hit  = 1'b1;
                o_lookup_data = entry_data[idx];
            end
        end
    end

    // Head entry is the write-back candidate
    assign o_req       = entry_valid[head_r];
    assign o_req_op    = ccu_pkg::MEM_OP_WRITE;
    assign o_req_addr  = entry_addr[head_r];
    assign o_req_wdata = entry_data[head_r];

endmodule

// File: hdl/ccu_vq_entry.sv
`timescale 1ns/1ns
`include "ccu_defines.svh"

module ccu_vq_entry (
    input  logic                                            clk,
    input  logic                                            i_reset,
    input  logic                                            i_alloc_en,
    input  logic [`CCU_ADDR_WIDTH-1:`CCU_OFFSET_WIDTH]      i_alloc_addr,
    input  logic [`CCU_LINE_WIDTH-1:0]                      i_alloc_data,
    input  logic                                            i_wb_done,
    input  logic [`CCU_ADDR_WIDTH-1:`CCU_OFFSET_WIDTH]      i_lookup_addr,
    output logic                                            o_valid,
    output logic [`CCU_ADDR_WIDTH-1:`CCU_OFFSET_WIDTH]      o_addr,
    output logic [`CCU_LINE_WIDTH-1:0]                      o_data,
    output logic                                            o_lookup_hit
);

    ccu_pkg::vq_entry_state_t state_r;
    ccu_pkg::vq_entry_state_t state_next;
    logic [`CCU_ADDR_WIDTH-1:`CCU_OFFSET_WIDTH] addr_r;
    logic [`CCU_LINE_WIDTH-1:0] data_r;

    // Filled on allocation, emptied once the line is written back
    always_comb begin
        state_next = state_r;
        case (state_r)
            ccu_pkg::INVALID: state_next = i_alloc_en ? ccu_pkg::VALID : state_r;
            ccu_pkg::VALID:   state_next = i_wb_done ? ccu_pkg::INVALID : state_r;
            default:          state_next = ccu_pkg::INVALID;
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state_r <= ccu_pkg::INVALID;
        end else begin
            state_r <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (i_alloc_en) begin
            addr_r <= i_alloc_addr;
            data_r <= i_alloc_data;
        end
    end

    assign o_valid      = (state_r == ccu_pkg::VALID);
    assign o_addr       = addr_r;
    assign o_data       = data_r;
    assign o_lookup_hit = o_valid && (addr_r == i_lookup_addr);

endmodule

// File: testbench/ccu_props.sv
`timescale 1ns/1ns
`include "ccu_defines.svh"

module ccu_props (
    input logic                         clk,
    input logic                         i_reset,
    input logic                         i_psel,
    input logic                         i_penable,
    input logic [`CCU_ADDR_WIDTH-1:0]   i_paddr,
    input logic                         i_pready,
    input logic                         i_victim_en,
    input logic                         i_vq_full
);

    int unsigned fail_count = 0;

    // A started transfer keeps PSEL until the slave answers
    psel_hold: assert property (@(posedge clk) disable iff (i_reset)
        i_psel && !(i_penable && i_pready) |=> i_psel)
        else begin
            $error("PSEL dropped before PREADY");
            fail_count++;
        end

    // ACCESS always follows a SETUP cycle
    penable_after_setup: assert property (@(posedge clk) disable iff (i_reset)
        $rose(i_penable) |-> i_psel && $past(i_psel))
        else begin
            $error("PENABLE rose without a SETUP cycle");
            fail_count++;
        end

    paddr_stable: assert property (@(posedge clk) disable iff (i_reset)
        i_psel && i_penable |-> $stable(i_paddr))
        else begin
            $error("PADDR changed during ACCESS");
            fail_count++;
        end

    no_alloc_when_full: assert property (@(posedge clk) disable iff (i_reset)
        i_victim_en |-> !i_vq_full)
        else begin
            $error("Victim allocated while the queue is full");
            fail_count++;
        end

endmodule

bind ccu_top ccu_props props_i (
    .clk         (clk),
    .i_reset     (i_reset),
    .i_psel      (o_psel),
    .i_penable   (o_penable),
    .i_paddr     (o_paddr),
    .i_pready    (i_pready),
    .i_victim_en (i_victim_en),
    .i_vq_full   (o_vq_full)
);

// File: testbench/ccu_tb.sv
`timescale 1ns/1ns
`include "ccu_defines.svh"

module ccu_tb;

    localparam int LINE_AW     = `CCU_ADDR_WIDTH - `CCU_OFFSET_WIDTH;
    localparam int NUM_ROWS    = 22;
    localparam int CYCLE_LIMIT = 200 * NUM_ROWS;

    typedef enum logic [1:0] {OP_VICTIM, OP_MISS, OP_DRAIN, OP_STALL} row_op_t;

    typedef struct packed {
        row_op_t                     op;
        logic [LINE_AW-1:0]          addr;
        logic [`CCU_LINE_WIDTH-1:0]  data;
    } row_t;

    // STALL rows hold PREADY low while data is 1 and release it when data is 0
    row_t rows [NUM_ROWS] = '{
        '{OP_VICTIM, 29'd10,  64'h1111_2222_3333_4444},
        '{OP_VICTIM, 29'd11,  64'h5555_6666_7777_8888},
        '{OP_VICTIM, 29'd12,  64'h9999_aaaa_bbbb_cccc},
        '{OP_MISS,   29'd11,  64'h0},
        '{OP_MISS,   29'd40,  64'h0},
        '{OP_DRAIN,  29'd0,   64'h0},
        '{OP_MISS,   29'd12,  64'h0},
        '{OP_VICTIM, 29'd20,  64'hdead_beef_0000_0020},
        '{OP_VICTIM, 29'd21,  64'h0123_4567_89ab_cdef},
        '{OP_VICTIM, 29'd20,  64'hfeed_face_0000_0200},
        '{OP_MISS,   29'd20,  64'h0},
        '{OP_MISS,   29'd100, 64'h0},
        '{OP_DRAIN,  29'd0,   64'h0},
        '{OP_STALL,  29'd0,   64'h1},
        '{OP_VICTIM, 29'd30,  64'h3030_0000_0000_3030},
        '{OP_VICTIM, 29'd31,  64'h3131_1111_1111_3131},
        '{OP_VICTIM, 29'd32,  64'h3232_2222_2222_3232},
        '{OP_VICTIM, 29'd33,  64'h3333_3333_3333_3333},
        '{OP_STALL,  29'd0,   64'h0},
        '{OP_DRAIN,  29'd0,   64'h0},
        '{OP_MISS,   29'd31,  64'h0},
        '{OP_MISS,   29'd7,   64'h0}
    };

    logic clk;
    logic reset = 1'b1;
    logic victim_en = 1'b0;
    logic [LINE_AW-1:0] victim_addr = '0;
    logic [`CCU_LINE_WIDTH-1:0] victim_data = '0;
    logic miss_en = 1'b0;
    logic [LINE_AW-1:0] miss_addr = '0;
    logic [`CCU_APB_DATA_WIDTH-1:0] prdata = '0;
    logic pready = 1'b0;
    logic vq_full;
    logic miss_busy;
    logic fill_valid;
    logic [LINE_AW-1:0] fill_addr;
    logic [`CCU_LINE_WIDTH-1:0] fill_data;
    logic psel;
    logic penable;
    logic pwrite;
    logic [`CCU_ADDR_WIDTH-1:0] paddr;
    logic [`CCU_APB_DATA_WIDTH-1:0] pwdata;

    // Word memory covering 4 KB, plus the reference lines seen as victims
    logic [31:0] mem [1024];
    logic written [1024] = '{default: 1'b0};
    logic [63:0] ref_line [512];
    logic ref_valid [512] = '{default: 1'b0};

    int alloc_count = 0;
    int wb_count = 0;
    int err_value = 0;
    int err_other = 0;
    int range_errors = 0;
    int cycles = 0;
    integer seed = 59;
    logic stall = 1'b0;

    ccu_top dut_i (
        .clk           (clk),
        .i_reset       (reset),
        .i_victim_en   (victim_en),
        .i_victim_addr (victim_addr),
        .i_victim_data (victim_data),
        .o_vq_full     (vq_full),
        .i_miss_en     (miss_en),
        .i_miss_addr   (miss_addr),
        .o_miss_busy   (miss_busy),
        .o_fill_valid  (fill_valid),
        .o_fill_addr   (fill_addr),
        .o_fill_data   (fill_data),
        .o_psel        (psel),
        .o_penable     (penable),
        .o_pwrite      (pwrite),
        .o_paddr       (paddr),
        .o_pwdata      (pwdata),
        .i_prdata      (prdata),
        .i_pready      (pready)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] fill_word(input logic [31:0] byte_addr);
        return (byte_addr * 32'h9e37_79b9) ^ 32'h0f1e_2d3c;
    endfunction

    // Newest victim data if the line was ever evicted, else the memory pattern
    function automatic logic [63:0] expected_line(input logic [LINE_AW-1:0] line_addr);
        logic [31:0] base;
        base = {line_addr, {`CCU_OFFSET_WIDTH{1'b0}}};
        if (ref_valid[line_addr[8:0]]) begin
            return ref_line[line_addr[8:0]];
        end
        return {fill_word(base + 32'd4), fill_word(base)};
    endfunction

    // APB slave with random wait states
    always @(posedge clk) begin
        if (reset) begin
            pready <= 1'b0;
        end else if (psel && penable && pready) begin
            if (pwrite) begin
                mem[paddr[11:2]]     = pwdata;
                written[paddr[11:2]] = 1'b1;
                if (paddr[2]) begin
                    wb_count <= wb_count + 1;
                end
            end
            pready <= 1'b0;
        end else if (psel) begin
            if (!penable && (paddr[31:12] != '0)) begin
                range_errors <= range_errors + 1;
                $display("APB access at address %h is outside the memory model", paddr);
            end
            pready <= !stall && (($random(seed) & 3) != 0);
            prdata <= written[paddr[11:2]] ? mem[paddr[11:2]] : fill_word(paddr);
        end
    end

    task automatic check_reset_state;
        @(posedge clk);
        if (psel || penable || fill_valid || miss_busy || vq_full) begin
            err_value++;
            $display("FAILED at %0t: outputs not idle after reset", $time);
        end
    endtask

    task automatic apply_victim(input logic [LINE_AW-1:0] addr, input logic [63:0] data);
        do @(posedge clk); while (vq_full);
        victim_en   <= 1'b1;
        victim_addr <= addr;
        victim_data <= data;
        ref_line[addr[8:0]]  = data;
        ref_valid[addr[8:0]] = 1'b1;
        alloc_count++;
        @(posedge clk);
        victim_en <= 1'b0;
    endtask

    task automatic apply_miss(input logic [LINE_AW-1:0] addr);
        logic [63:0] expected;
        expected = expected_line(addr);
        do @(posedge clk); while (miss_busy);
        miss_en   <= 1'b1;
        miss_addr <= addr;
        @(posedge clk);
        miss_en <= 1'b0;
        do @(posedge clk); while (!fill_valid);
        if (fill_addr !== addr) begin
            err_value++;
            $display("FAILED at %0t: fill address %h, expected %h", $time, fill_addr, addr);
        end
        if (fill_data !== expected) begin
            err_value++;
            $display("FAILED at %0t: fill data for line %h is %h, expected %h",
                     $time, addr, fill_data, expected);
        end
    endtask

    // Wait until every allocated line has finished its second beat
    task automatic drain_queue;
        int i;
        do @(posedge clk); while (wb_count != alloc_count);
        if (vq_full !== 1'b0) begin
            err_value++;
            $display("FAILED at %0t: o_vq_full still high after the queue drained", $time);
        end
        for (i = 0; i < 512; i++) begin
            if (ref_valid[i] && (!written[2*i] || !written[2*i+1])) begin
                err_other++;
                $display("Line %0d was never written back to memory", i);
            end else if (ref_valid[i] && ({mem[2*i+1], mem[2*i]} !== ref_line[i])) begin
                err_value++;
                $display("FAILED at %0t: memory line %0d is %h, expected %h",
                         $time, i, {mem[2*i+1], mem[2*i]}, ref_line[i]);
            end
        end
    endtask

    task automatic set_stall(input logic hold);
        @(posedge clk);
        if (!hold && (vq_full !== 1'b1)) begin
            err_value++;
            $display("FAILED at %0t: o_vq_full low with a full queue behind a stall", $time);
        end
        stall <= hold;
    endtask

    initial begin
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: run stopped after %0d cycles", cycles);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        int row;
        int total;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        check_reset_state();
        for (row = 0; row < NUM_ROWS; row++) begin
            case (rows[row].op)
                OP_VICTIM: apply_victim(rows[row].addr, rows[row].data);
                OP_MISS:   apply_miss(rows[row].addr);
                OP_DRAIN:  drain_queue();
                default:   set_stall(rows[row].data[0]);
            endcase
        end
        total = err_value + err_other + range_errors + dut_i.props_i.fail_count;
        $display("Errors: %0d value, %0d other, %0d assertion",
                 err_value, err_other + range_errors, dut_i.props_i.fail_count);
        if (total == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
